/* cache_pkg.sv */
/*
  bus widths, cache geometry and memory latency constants,
  APB request/response structs and FSM state enums
*/
package cache_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // byte offset inside one word
  localparam int OFF_W = 2;

  // direct-mapped L1, one word per line
  localparam int LINES = 32;
  localparam int IDX_W = $clog2(LINES);
  localparam int TAG_W = ADDR_W - IDX_W - OFF_W;

  // main memory depth and pacing
  localparam int MEM_WORDS = 1024;
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);
  localparam int MEM_WAIT  = 2;
  localparam int WAIT_W    = $clog2(MEM_WAIT + 1);

  typedef logic [DATA_W-1:0]    word_t;
  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [IDX_W-1:0]     idx_t;
  typedef logic [TAG_W-1:0]     tag_t;
  typedef logic [MEM_IDX_W-1:0] mem_idx_t;
  typedef logic [WAIT_W-1:0]    wait_t;

  // requester side of an APB link
  typedef struct packed {
    logic  sel;
    logic  enable;
    logic  write;
    addr_t addr;
    word_t wdata;
  } apb_req_t;

  // completer side
  typedef struct packed {
    logic  ready;
    word_t rdata;
  } apb_rsp_t;

  typedef enum logic [2:0] {
    l1_idle,
    l1_lookup,
    l1_mem_setup,
    l1_mem_access,
    l1_clearing
  } l1_state_t;

  typedef enum logic [1:0] {
    arb_idle,
    arb_grant_d,
    arb_grant_i
  } arb_state_t;

endpackage

/* l1_cache.sv */
/*
  direct-mapped write-through L1 cache
  APB completer towards the core, APB requester towards memory,
  line-by-line clear sequencer
*/
`timescale 1ns/100ps

module l1_cache
  import cache_pkg::*;
(
  input  logic     CLK,
  input  logic     i_arst_n,
  input  logic     i_clear,
  output logic     o_clear_done,
  input  apb_req_t i_cpu_req,
  output apb_rsp_t o_cpu_rsp,
  output apb_req_t o_mem_req,
  input  apb_rsp_t i_mem_rsp
);

  l1_state_t state;
  l1_state_t state_nxt;

  // clear walker
  idx_t clear_cnt;
  logic clear_pend;

  // line storage
  logic [LINES-1:0] valid;
  tag_t             tags [LINES];
  word_t            data [LINES];

  idx_t  req_idx;
  tag_t  req_tag;
  logic  hit;
  logic  hit_done;
  logic  take_clear;
  logic  mem_done;
  logic  line_wr;
  word_t line_wdata;

  // core holds addr and wdata stable until ready, so no capture registers
  assign req_idx = i_cpu_req.addr[OFF_W +: IDX_W];
  assign req_tag = i_cpu_req.addr[ADDR_W-1 -: TAG_W];
  assign hit     = valid[req_idx] && (tags[req_idx] == req_tag);

  // read hit answered in the first access cycle
  assign hit_done = (state == l1_lookup) && i_cpu_req.sel && i_cpu_req.enable &&
                    !i_cpu_req.write && hit;

  // clear only starts from idle, a late pulse is remembered
  assign take_clear = (state == l1_idle) && (i_clear || clear_pend);

  assign mem_done = (state == l1_mem_access) && i_mem_rsp.ready;

  // fill on read miss, update on write hit, no allocate on write miss
  assign line_wr    = mem_done && (!i_cpu_req.write || hit);
  assign line_wdata = i_cpu_req.write ? i_cpu_req.wdata : i_mem_rsp.rdata;

  // last line being invalidated
  assign o_clear_done = (state == l1_clearing) && (clear_cnt == idx_t'(LINES - 1));

  always_comb begin
    state_nxt = state;
    case (state)
      l1_idle: begin
        // clear wins over a new core request
        if (take_clear) begin
          state_nxt = l1_clearing;
        end else if (i_cpu_req.sel) begin
          state_nxt = l1_lookup;
        end
      end
      l1_lookup: begin
        if (!i_cpu_req.sel) begin
          state_nxt = l1_idle;
        end else if (hit_done) begin
          state_nxt = l1_idle;
        end else if (i_cpu_req.enable) begin
          // read miss or any write
          state_nxt = l1_mem_setup;
        end
      end
      l1_mem_setup: begin
        state_nxt = l1_mem_access;
      end
      l1_mem_access: begin
        if (i_mem_rsp.ready) begin
          state_nxt = l1_idle;
        end
      end
      l1_clearing: begin
        if (o_clear_done) begin
          state_nxt = l1_idle;
        end
      end
      default: begin
        state_nxt = l1_idle;
      end
    endcase
  end

  always_ff @(posedge CLK or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state      <= l1_idle;
      clear_cnt  <= '0;
      clear_pend <= 1'b0;
      valid      <= '0;
    end else begin
      state <= state_nxt;
      if (take_clear) begin
        clear_pend <= 1'b0;
      end else if (i_clear) begin
        clear_pend <= 1'b1;
      end
      if (state == l1_clearing) begin
        // one line per cycle
        valid[clear_cnt] <= 1'b0;
        clear_cnt        <= clear_cnt + 1'b1;
      end else begin
        clear_cnt <= '0;
        if (line_wr) begin
          valid[req_idx] <= 1'b1;
        end
      end
    end
  end

  // tag and data arrays
  always_ff @(posedge CLK) begin
    if (line_wr) begin
      tags[req_idx] <= req_tag;
      data[req_idx] <= line_wdata;
    end
  end

  // response to the core
  always_comb begin
    o_cpu_rsp = '0;
    if (hit_done) begin
      o_cpu_rsp.ready = 1'b1;
      o_cpu_rsp.rdata = data[req_idx];
    end else if (mem_done) begin
      // read data straight from memory on a fill
      o_cpu_rsp.ready = 1'b1;
      o_cpu_rsp.rdata = i_mem_rsp.rdata;
    end
  end

  // request to the arbiter
  always_comb begin
    o_mem_req = '0;
    if ((state == l1_mem_setup) || (state == l1_mem_access)) begin
      o_mem_req.sel    = 1'b1;
      o_mem_req.enable = (state == l1_mem_access);
      o_mem_req.write  = i_cpu_req.write;
      o_mem_req.addr   = i_cpu_req.addr;
      o_mem_req.wdata  = i_cpu_req.wdata;
    end
  end

endmodule

/* memory_arbiter.sv */
/*
  two-requester APB arbiter for the shared memory bus
  data cache has fixed priority, grant held until ready
*/
`timescale 1ns/100ps

module memory_arbiter
  import cache_pkg::*;
(
  input  logic     CLK,
  input  logic     i_arst_n,
  input  apb_req_t i_icache_req,
  output apb_rsp_t o_icache_rsp,
  input  apb_req_t i_dcache_req,
  output apb_rsp_t o_dcache_rsp,
  output apb_req_t o_mem_req,
  input  apb_rsp_t i_mem_rsp
);

  arb_state_t state;
  arb_state_t state_nxt;

  logic route_d;
  logic route_i;

  // in idle the winner passes through in the same cycle
  assign route_d = (state == arb_grant_d) ||
                   ((state == arb_idle) && i_dcache_req.sel);
  assign route_i = (state == arb_grant_i) ||
                   ((state == arb_idle) && !i_dcache_req.sel && i_icache_req.sel);

  always_comb begin
    state_nxt = state;
    case (state)
      arb_idle: begin
        if (i_dcache_req.sel) begin
          state_nxt = arb_grant_d;
        end else if (i_icache_req.sel) begin
          state_nxt = arb_grant_i;
        end
      end
      arb_grant_d, arb_grant_i: begin
        // release at the end of the granted transfer
        if (i_mem_rsp.ready) begin
          state_nxt = arb_idle;
        end
      end
      default: begin
        state_nxt = arb_idle;
      end
    endcase
  end

  always_ff @(posedge CLK or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= arb_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    if (route_d) begin
      o_mem_req = i_dcache_req;
    end else if (route_i) begin
      o_mem_req = i_icache_req;
    end else begin
      o_mem_req = '0;
    end
    // grant cycle is always a setup cycle for memory,
    // a loser may already sit in its access phase
    if (state == arb_idle) begin
      o_mem_req.enable = 1'b0;
    end
  end

  // only the grant holder sees ready, the other one stalls
  always_comb begin
    o_dcache_rsp = '0;
    o_icache_rsp = '0;
    if (state == arb_grant_d) begin
      o_dcache_rsp = i_mem_rsp;
    end else if (state == arb_grant_i) begin
      o_icache_rsp = i_mem_rsp;
    end
  end

endmodule

/* main_memory.sv */
/*
  word-addressed RAM behind an APB completer
  fixed MEM_WAIT wait states on every access
*/
`timescale 1ns/100ps

module main_memory
  import cache_pkg::*;
(
  input  logic     CLK,
  input  logic     i_arst_n,
  input  apb_req_t i_req,
  output apb_rsp_t o_rsp
);

  // storage, all zero at start
  word_t mem [MEM_WORDS] = '{default: '0};

  wait_t    wait_cnt;
  mem_idx_t word_idx;
  logic     access;
  logic     ready;

  // upper address bits ignored, so addresses wrap over the depth
  assign word_idx = i_req.addr[OFF_W +: MEM_IDX_W];

  assign access = i_req.sel && i_req.enable;
  assign ready  = access && (wait_cnt == wait_t'(MEM_WAIT));

  // wait counter restarts on every setup phase
  always_ff @(posedge CLK or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wait_cnt <= '0;
    end else if (i_req.sel && !i_req.enable) begin
      wait_cnt <= '0;
    end else if (ready) begin
      wait_cnt <= '0;
    end else if (access) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // write lands at the end of the access phase
  always_ff @(posedge CLK) begin
    if (ready && i_req.write) begin
      mem[word_idx] <= i_req.wdata;
    end
  end

  always_comb begin
    o_rsp       = '0;
    o_rsp.ready = ready;
    // read data only valid alongside ready
    if (ready && !i_req.write) begin
      o_rsp.rdata = mem[word_idx];
    end
  end

endmodule

/* caches_top.sv */
/*
  instruction and data L1 caches sharing main memory
  through the memory arbiter
*/
`timescale 1ns/100ps

module caches_top
  import cache_pkg::*;
(
  input  logic     CLK,
  input  logic     i_arst_n,
  input  logic     i_iclear,
  output logic     o_iclear_done,
  input  logic     i_dclear,
  output logic     o_dclear_done,
  input  apb_req_t i_icpu_req,
  output apb_rsp_t o_icpu_rsp,
  input  apb_req_t i_dcpu_req,
  output apb_rsp_t o_dcpu_rsp
);

  // cache to arbiter links
  apb_req_t icache_mem_req;
  apb_rsp_t icache_mem_rsp;
  apb_req_t dcache_mem_req;
  apb_rsp_t dcache_mem_rsp;

  // arbiter to memory link
  apb_req_t arb_mem_req;
  apb_rsp_t arb_mem_rsp;

  l1_cache icache_i (
    .CLK          (CLK),
    .i_arst_n     (i_arst_n),
    .i_clear      (i_iclear),
    .o_clear_done (o_iclear_done),
    .i_cpu_req    (i_icpu_req),
    .o_cpu_rsp    (o_icpu_rsp),
    .o_mem_req    (icache_mem_req),
    .i_mem_rsp    (icache_mem_rsp)
  );

  l1_cache dcache_i (
    .CLK          (CLK),
    .i_arst_n     (i_arst_n),
    .i_clear      (i_dclear),
    .o_clear_done (o_dclear_done),
    .i_cpu_req    (i_dcpu_req),
    .o_cpu_rsp    (o_dcpu_rsp),
    .o_mem_req    (dcache_mem_req),
    .i_mem_rsp    (dcache_mem_rsp)
  );

  memory_arbiter arb_i (
    .CLK          (CLK),
    .i_arst_n     (i_arst_n),
    .i_icache_req (icache_mem_req),
    .o_icache_rsp (icache_mem_rsp),
    .i_dcache_req (dcache_mem_req),
    .o_dcache_rsp (dcache_mem_rsp),
    .o_mem_req    (arb_mem_req),
    .i_mem_rsp    (arb_mem_rsp)
  );

  main_memory mem_i (
    .CLK      (CLK),
    .i_arst_n (i_arst_n),
    .i_req    (arb_mem_req),
    .o_rsp    (arb_mem_rsp)
  );

endmodule

/* tb_caches_top.sv */
/*
  testbench for caches_top: clock and reset, APB core transfers,
  LFSR stimulus, memory scoreboard and assertion checks
*/
`timescale 1ns/100ps

module tb_caches_top
  import cache_pkg::*;
();

  localparam int XFER_TIMEOUT  = 100;
  localparam int CLEAR_TIMEOUT = LINES + 20;
  localparam int N_RAND        = 32;

  logic     clk = 1'b0;
  logic     arst_n;
  logic     iclear;
  logic     dclear;
  logic     iclear_done;
  logic     dclear_done;
  apb_req_t icpu_req;
  apb_req_t dcpu_req;
  apb_rsp_t icpu_rsp;
  apb_rsp_t dcpu_rsp;

  int          err_cnt;
  int          pass_cnt;
  int          fail_cnt;
  int          test_err_base;
  int          dclear_pulses;
  logic        check_reset;
  logic [15:0] lfsr;

  // mirror of main memory, every write goes through
  word_t sb [MEM_WORDS];
  addr_t wr_addr [N_RAND];

  caches_top dut_i (
    .CLK           (clk),
    .i_arst_n      (arst_n),
    .i_iclear      (iclear),
    .o_iclear_done (iclear_done),
    .i_dclear      (dclear),
    .o_dclear_done (dclear_done),
    .i_icpu_req    (icpu_req),
    .o_icpu_rsp    (icpu_rsp),
    .i_dcpu_req    (dcpu_req),
    .o_dcpu_rsp    (dcpu_rsp)
  );

  always #20 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // memory wraps over its depth
  function automatic int word_of(input addr_t a);
    word_of = (a >> OFF_W) % MEM_WORDS;
  endfunction

  task automatic abort_run(input string what);
    $display("%s at %0t", what, $time);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t got);
    assert (got === exp) else begin
      $display("** Error: %s expected 0x%h got 0x%h", name, exp, got);
      err_cnt++;
    end
  endtask

  // hit means ready in the first access cycle
  task automatic check_hit(input bit want_hit, input string port, input addr_t a,
                           input int cyc);
    assert ((cyc == 1) == want_hit) else begin
      $display("%s read of 0x%h took %0d access cycles, expected a %s", port, a, cyc,
               want_hit ? "hit" : "miss");
      err_cnt++;
    end
  endtask

  task automatic begin_test();
    test_err_base = err_cnt;
  endtask

  task automatic end_test(input int num, input string name);
    if (err_cnt == test_err_base) begin
      pass_cnt++;
      $display("test %0d %s: pass", num, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: fail", num, name);
    end
  endtask

  task automatic drive_req(input bit dport, input apb_req_t r);
    if (dport) begin
      dcpu_req = r;
    end else begin
      icpu_req = r;
    end
  endtask

  // one APB transfer, entered and left 2 ns after a rising edge
  task automatic cpu_xfer(input bit dport, input bit wr, input addr_t a, input word_t wd,
                          output word_t rd, output int cycles, output time t_ready);
    apb_req_t req;
    apb_rsp_t rsp;
    int       n;
    req       = '0;
    req.sel   = 1'b1;
    req.write = wr;
    req.addr  = a;
    req.wdata = wd;
    drive_req(dport, req);
    @(posedge clk);
    #2;
    req.enable = 1'b1;
    drive_req(dport, req);
    // sample mid-cycle, n counts access cycles
    n = 1;
    @(negedge clk);
    rsp = dport ? dcpu_rsp : icpu_rsp;
    while ((rsp.ready !== 1'b1) && (n <= XFER_TIMEOUT)) begin
      @(negedge clk);
      rsp = dport ? dcpu_rsp : icpu_rsp;
      n++;
    end
    if (rsp.ready !== 1'b1) begin
      abort_run(dport ? "no ready on the data port" : "no ready on the instruction port");
    end else begin
      rd      = rsp.rdata;
      cycles  = n;
      t_ready = $time;
      @(posedge clk);
      #2;
      drive_req(dport, apb_req_t'('0));
    end
  endtask

  // one-cycle clear pulse, returns the cycle of clear_done
  task automatic pulse_clear(input bit dport, output int done_at);
    int n;
    if (dport) begin
      dclear = 1'b1;
    end else begin
      iclear = 1'b1;
    end
    @(posedge clk);
    #2;
    dclear = 1'b0;
    iclear = 1'b0;
    n = 1;
    @(negedge clk);
    while (((dport ? dclear_done : iclear_done) !== 1'b1) && (n <= CLEAR_TIMEOUT)) begin
      @(negedge clk);
      n++;
    end
    if ((dport ? dclear_done : iclear_done) !== 1'b1) begin
      abort_run("no clear_done after a clear request");
    end else begin
      done_at = n;
      @(posedge clk);
      #2;
    end
  endtask

  // outputs quiet around reset
  assert property (@(negedge clk) check_reset |->
                   (icpu_rsp.ready === 1'b0 && dcpu_rsp.ready === 1'b0 &&
                    iclear_done === 1'b0 && dclear_done === 1'b0))
    else begin
      $display("a ready or clear_done was not low around reset at %0t", $time);
      err_cnt++;
    end

  always @(negedge clk) begin
    if (dclear_done === 1'b1) begin
      dclear_pulses++;
    end
  end

  initial begin
    word_t       rd;
    word_t       ird;
    word_t       drd;
    word_t       wd;
    word_t       old;
    addr_t       a;
    addr_t       ia;
    addr_t       da;
    logic [31:0] r;
    int          cyc;
    int          icyc;
    int          dcyc;
    int          base;
    time         t;
    time         it;
    time         dt;
    arst_n        = 1'b0;
    iclear        = 1'b0;
    dclear        = 1'b0;
    icpu_req      = '0;
    dcpu_req      = '0;
    err_cnt       = 0;
    pass_cnt      = 0;
    fail_cnt      = 0;
    dclear_pulses = 0;
    check_reset   = 1'b1;
    lfsr          = 16'd47670;
    for (int k = 0; k < MEM_WORDS; k++) begin
      sb[k] = '0;
    end

    // reset for 3 cycles, watched two more
    begin_test();
    repeat (3) @(posedge clk);
    #2;
    arst_n = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    check_reset = 1'b0;
    end_test(6, "reset state");

    begin_test();
    for (int k = 0; k < N_RAND; k++) begin
      draw_bits(MEM_IDX_W, r);
      a = r << OFF_W;
      draw_bits(DATA_W, wd);
      wr_addr[k] = a;
      cpu_xfer(1'b1, 1'b1, a, wd, rd, cyc, t);
      sb[word_of(a)] = wd;
      cpu_xfer(1'b1, 1'b0, a, '0, rd, cyc, t);
      check_word("o_dcpu_rsp.rdata", sb[word_of(a)], rd);
    end
    // second pass catches lines evicted by aliasing
    for (int k = 0; k < N_RAND; k++) begin
      cpu_xfer(1'b1, 1'b0, wr_addr[k], '0, rd, cyc, t);
      check_word("o_dcpu_rsp.rdata", sb[word_of(wr_addr[k])], rd);
    end
    end_test(1, "write through and read back");

    begin_test();
    draw_bits(MEM_IDX_W, r);
    a = r << OFF_W;
    cpu_xfer(1'b0, 1'b0, a, '0, rd, cyc, t);
    check_word("o_icpu_rsp.rdata", sb[word_of(a)], rd);
    cpu_xfer(1'b0, 1'b0, a, '0, rd, cyc, t);
    check_word("o_icpu_rsp.rdata", sb[word_of(a)], rd);
    check_hit(1'b1, "instruction", a, cyc);
    draw_bits(MEM_IDX_W, r);
    a = r << OFF_W;
    cpu_xfer(1'b1, 1'b0, a, '0, rd, cyc, t);
    check_word("o_dcpu_rsp.rdata", sb[word_of(a)], rd);
    cpu_xfer(1'b1, 1'b0, a, '0, rd, cyc, t);
    check_word("o_dcpu_rsp.rdata", sb[word_of(a)], rd);
    check_hit(1'b1, "data", a, cyc);
    end_test(2, "hit timing");

    // fresh tags above the memory depth force misses on both ports
    begin_test();
    draw_bits(MEM_IDX_W, r);
    ia = (r << OFF_W) + 32'h0004_0000;
    draw_bits(MEM_IDX_W, r);
    da = (r << OFF_W) + 32'h0008_0000;
    fork
      cpu_xfer(1'b0, 1'b0, ia, '0, ird, icyc, it);
      cpu_xfer(1'b1, 1'b0, da, '0, drd, dcyc, dt);
    join
    check_word("o_icpu_rsp.rdata", sb[word_of(ia)], ird);
    check_word("o_dcpu_rsp.rdata", sb[word_of(da)], drd);
    check_hit(1'b0, "instruction", ia, icyc);
    check_hit(1'b0, "data", da, dcyc);
    assert (dt < it) else begin
      $display("data port did not win arbitration, ready at %0t vs %0t", dt, it);
      err_cnt++;
    end
    end_test(3, "shared memory arbitration");

    begin_test();
    draw_bits(MEM_IDX_W, r);
    a   = r << OFF_W;
    old = sb[word_of(a)];
    cpu_xfer(1'b0, 1'b0, a, '0, rd, cyc, t);
    check_word("o_icpu_rsp.rdata", old, rd);
    draw_bits(DATA_W, wd);
    if (wd == old) begin
      wd = ~old;
    end
    cpu_xfer(1'b1, 1'b1, a, wd, rd, cyc, t);
    sb[word_of(a)] = wd;
    // icache still holds the old line
    cpu_xfer(1'b0, 1'b0, a, '0, rd, cyc, t);
    check_word("o_icpu_rsp.rdata", old, rd);
    pulse_clear(1'b0, cyc);
    cpu_xfer(1'b0, 1'b0, a, '0, rd, cyc, t);
    check_word("o_icpu_rsp.rdata", wd, rd);
    end_test(4, "clear and stale data");

    begin_test();
    base = dclear_pulses;
    pulse_clear(1'b1, cyc);
    assert (cyc == LINES) else begin
      $display("clear_done came %0d cycles after the clear, expected %0d", cyc, LINES);
      err_cnt++;
    end
    repeat (LINES) @(posedge clk);
    #2;
    assert (dclear_pulses == base + 1) else begin
      $display("clear_done pulsed %0d times for one clear", dclear_pulses - base);
      err_cnt++;
    end
    cpu_xfer(1'b1, 1'b0, wr_addr[0], '0, rd, cyc, t);
    check_word("o_dcpu_rsp.rdata", sb[word_of(wr_addr[0])], rd);
    check_hit(1'b0, "data", wr_addr[0], cyc);
    end_test(5, "clear protocol");

    $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
             pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
cache_pkg.sv
l1_cache.sv
memory_arbiter.sv
main_memory.sv
caches_top.sv
tb_caches_top.sv

/* Bender.yml */
# two-cache memory subsystem with shared main memory

package:
  name: caches_top

sources:
  # package first, then leaf modules, then the top level
  - cache_pkg.sv
  - l1_cache.sv
  - memory_arbiter.sv
  - main_memory.sv
  - caches_top.sv

  # self-checking testbench
  - target: test
    files:
      - tb_caches_top.sv
